// File: hw/la_id_params.svh
`ifndef LA_ID_PARAMS_SVH
`define LA_ID_PARAMS_SVH

`define LA_GRLEN    32
`define LA_RADDR_W  5
`define LA_NREGS    32

// memory size codes, top bit set for unsigned loads
`define LA_MEM_W    3'b000
`define LA_MEM_H    3'b001
`define LA_MEM_B    3'b010
`define LA_MEM_UNS  3'b100

// inst[31:15], three-register and ui5 shift forms
`define LA_OP_ADD_W   17'h00020
`define LA_OP_SUB_W   17'h00022
`define LA_OP_SLT     17'h00024
`define LA_OP_SLTU    17'h00025
`define LA_OP_NOR     17'h00028
`define LA_OP_AND     17'h00029
`define LA_OP_OR      17'h0002a
`define LA_OP_XOR     17'h0002b
`define LA_OP_SLL_W   17'h0002e
`define LA_OP_SRL_W   17'h0002f
`define LA_OP_SRA_W   17'h00030
`define LA_OP_SLLI_W  17'h00081
`define LA_OP_SRLI_W  17'h00089
`define LA_OP_SRAI_W  17'h00091

// inst[31:22], si12 and ui12 forms
`define LA_OP_SLTI    10'h008
`define LA_OP_SLTUI   10'h009
`define LA_OP_ADDI_W  10'h00a
`define LA_OP_ANDI    10'h00d
`define LA_OP_ORI     10'h00e
`define LA_OP_XORI    10'h00f
`define LA_OP_LD_B    10'h0a0
`define LA_OP_LD_H    10'h0a1
`define LA_OP_LD_W    10'h0a2
`define LA_OP_ST_B    10'h0a4
`define LA_OP_ST_H    10'h0a5
`define LA_OP_ST_W    10'h0a6
`define LA_OP_LD_BU   10'h0a8
`define LA_OP_LD_HU   10'h0a9

// inst[31:25]
`define LA_OP_LU12I_W    7'h0a
`define LA_OP_PCADDU12I  7'h0e

// inst[31:26]
`define LA_OP_JIRL  6'h13
`define LA_OP_B     6'h14
`define LA_OP_BL    6'h15
`define LA_OP_BEQ   6'h16
`define LA_OP_BNE   6'h17
`define LA_OP_BLT   6'h18
`define LA_OP_BGE   6'h19
`define LA_OP_BLTU  6'h1a
`define LA_OP_BGEU  6'h1b

`endif

// File: hw/la_id_pkg.sv
`include "la_id_params.svh"

package la_id_pkg;

    // three-register view, also used for ui5 shifts
    typedef struct packed {
        logic [16:0]             op;
        logic [`LA_RADDR_W-1:0]  rk;
        logic [`LA_RADDR_W-1:0]  rj;
        logic [`LA_RADDR_W-1:0]  rd;
    } inst_r3_t;

    typedef struct packed {
        logic [9:0]              op;
        logic [11:0]             i12;
        logic [`LA_RADDR_W-1:0]  rj;
        logic [`LA_RADDR_W-1:0]  rd;
    } inst_ri_t;

    typedef union packed {
        inst_r3_t r3;
        inst_ri_t ri;
    } inst_word_u;

    typedef struct packed {
        logic [`LA_GRLEN-1:0] pc;
        inst_word_u           inst;
    } if_id_t;

    typedef struct packed {
        logic [11:0]             alu_op;
        logic                    src1_is_pc;
        logic                    src2_is_imm;
        logic                    need_rj;
        logic                    need_rkd;
        logic [`LA_RADDR_W-1:0]  raddr1;
        logic [`LA_RADDR_W-1:0]  raddr2;
        logic [`LA_RADDR_W-1:0]  dest;
        logic                    gr_we;
        logic                    mem_we;
        logic                    res_from_mem;
        logic [2:0]              mem_type;
        logic [3:0]              br_kind;   // [3] invert, [2:0] ltu/lt/eq
        logic                    is_jump;
    } dec_ctrl_t;

    typedef struct packed {
        logic                    valid;
        logic                    is_load;
        logic [`LA_RADDR_W-1:0]  dest;
        logic [`LA_GRLEN-1:0]    wdata;
    } fwd_src_t;

    typedef struct packed {
        logic                    we;
        logic [`LA_RADDR_W-1:0]  waddr;
        logic [`LA_GRLEN-1:0]    wdata;
    } wb_write_t;

    typedef struct packed {
        logic                 taken;
        logic [`LA_GRLEN-1:0] target;
    } br_redirect_t;

    typedef struct packed {
        logic [11:0]             alu_op;
        logic [`LA_GRLEN-1:0]    src1;
        logic [`LA_GRLEN-1:0]    src2;
        logic [`LA_GRLEN-1:0]    rkd_value;   // store data
        logic [`LA_RADDR_W-1:0]  dest;
        logic                    gr_we;
        logic                    mem_we;
        logic                    res_from_mem;
        logic [2:0]              mem_type;
        logic [`LA_GRLEN-1:0]    pc;
    } id_ex_t;

endpackage

// File: hw/id_decoder.sv
`timescale 1ns/10ps
`include "la_id_params.svh"

module id_decoder (
    input  la_id_pkg::inst_word_u   inst,
    output la_id_pkg::dec_ctrl_t    ctrl,
    output logic [`LA_GRLEN-1:0]    imm,
    output logic [`LA_GRLEN-1:0]    br_offs
);
    logic [5:0]  op6;
    logic [6:0]  op7;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic i_add, i_sub, i_slt, i_sltu, i_nor, i_and, i_or, i_xor;
    logic i_sll, i_srl, i_sra, i_slli, i_srli, i_srai;
    logic i_addi, i_slti, i_sltui, i_andi, i_ori, i_xori, i_lu12i, i_pcadd;
    logic i_ld_w, i_ld_h, i_ld_b, i_ld_hu, i_ld_bu, i_st_w, i_st_h, i_st_b;
    logic i_jirl, i_b, i_bl, i_beq, i_bne, i_blt, i_bge, i_bltu, i_bgeu;
    logic is_rrr, shift_imm, si12, ui12, u20, link, is_load, is_store, is_cbr;

    assign op6 = inst.ri.op[9:4];
    assign op7 = inst.ri.op[9:3];

    // wide immediates pieced together from the ri view
    assign i20 = {inst.ri.op[2:0], inst.ri.i12, inst.ri.rj};
    assign i16 = {inst.ri.op[3:0], inst.ri.i12};
    assign i26 = {inst.ri.rj, inst.ri.rd, inst.ri.op[3:0], inst.ri.i12};

    assign i_add   = inst.r3.op == `LA_OP_ADD_W;
    assign i_sub   = inst.r3.op == `LA_OP_SUB_W;
    assign i_slt   = inst.r3.op == `LA_OP_SLT;
    assign i_sltu  = inst.r3.op == `LA_OP_SLTU;
    assign i_nor   = inst.r3.op == `LA_OP_NOR;
    assign i_and   = inst.r3.op == `LA_OP_AND;
    assign i_or    = inst.r3.op == `LA_OP_OR;
    assign i_xor   = inst.r3.op == `LA_OP_XOR;
    assign i_sll   = inst.r3.op == `LA_OP_SLL_W;
    assign i_srl   = inst.r3.op == `LA_OP_SRL_W;
    assign i_sra   = inst.r3.op == `LA_OP_SRA_W;
    assign i_slli  = inst.r3.op == `LA_OP_SLLI_W;
    assign i_srli  = inst.r3.op == `LA_OP_SRLI_W;
    assign i_srai  = inst.r3.op == `LA_OP_SRAI_W;

    assign i_addi  = inst.ri.op == `LA_OP_ADDI_W;
    assign i_slti  = inst.ri.op == `LA_OP_SLTI;
    assign i_sltui = inst.ri.op == `LA_OP_SLTUI;
    assign i_andi  = inst.ri.op == `LA_OP_ANDI;
    assign i_ori   = inst.ri.op == `LA_OP_ORI;
    assign i_xori  = inst.ri.op == `LA_OP_XORI;
    assign i_ld_w  = inst.ri.op == `LA_OP_LD_W;
    assign i_ld_h  = inst.ri.op == `LA_OP_LD_H;
    assign i_ld_b  = inst.ri.op == `LA_OP_LD_B;
    assign i_ld_hu = inst.ri.op == `LA_OP_LD_HU;
    assign i_ld_bu = inst.ri.op == `LA_OP_LD_BU;
    assign i_st_w  = inst.ri.op == `LA_OP_ST_W;
    assign i_st_h  = inst.ri.op == `LA_OP_ST_H;
    assign i_st_b  = inst.ri.op == `LA_OP_ST_B;

    assign i_lu12i = op7 == `LA_OP_LU12I_W;
    assign i_pcadd = op7 == `LA_OP_PCADDU12I;
    assign i_jirl  = op6 == `LA_OP_JIRL;
    assign i_b     = op6 == `LA_OP_B;
    assign i_bl    = op6 == `LA_OP_BL;
    assign i_beq   = op6 == `LA_OP_BEQ;
    assign i_bne   = op6 == `LA_OP_BNE;
    assign i_blt   = op6 == `LA_OP_BLT;
    assign i_bge   = op6 == `LA_OP_BGE;
    assign i_bltu  = op6 == `LA_OP_BLTU;
    assign i_bgeu  = op6 == `LA_OP_BGEU;

    assign is_rrr = i_add | i_sub | i_slt | i_sltu | i_nor | i_and | i_or | i_xor
                  | i_sll | i_srl | i_sra;
    assign shift_imm = i_slli | i_srli | i_srai;
    assign is_load   = i_ld_w | i_ld_h | i_ld_b | i_ld_hu | i_ld_bu;
    assign is_store  = i_st_w | i_st_h | i_st_b;
    assign is_cbr    = i_beq | i_bne | i_blt | i_bge | i_bltu | i_bgeu;
    assign si12      = i_addi | i_slti | i_sltui | is_load | is_store;
    assign ui12      = i_andi | i_ori | i_xori;
    assign u20       = i_lu12i | i_pcadd;
    assign link      = i_jirl | i_bl;   // write pc+4

    always_comb begin
        ctrl.alu_op[0]  = i_add | i_addi | is_load | is_store | link | i_pcadd;
        ctrl.alu_op[1]  = i_sub;
        ctrl.alu_op[2]  = i_slt | i_slti;
        ctrl.alu_op[3]  = i_sltu | i_sltui;
        ctrl.alu_op[4]  = i_and | i_andi;
        ctrl.alu_op[5]  = i_nor;
        ctrl.alu_op[6]  = i_or | i_ori;
        ctrl.alu_op[7]  = i_xor | i_xori;
        ctrl.alu_op[8]  = i_sll | i_slli;
        ctrl.alu_op[9]  = i_srl | i_srli;
        ctrl.alu_op[10] = i_sra | i_srai;
        ctrl.alu_op[11] = i_lu12i;
        ctrl.src1_is_pc   = link | i_pcadd;
        ctrl.src2_is_imm  = shift_imm | si12 | ui12 | u20 | link;
        ctrl.need_rj      = is_rrr | shift_imm | si12 | ui12 | is_cbr | i_jirl;
        ctrl.need_rkd     = is_rrr | is_store | is_cbr;
        ctrl.raddr1       = inst.r3.rj;
        ctrl.raddr2       = (is_store | is_cbr) ? inst.r3.rd : inst.r3.rk;
        ctrl.dest         = i_bl ? `LA_RADDR_W'd1 : inst.r3.rd;
        ctrl.gr_we        = is_rrr | shift_imm | i_addi | i_slti | i_sltui | ui12 | u20
                          | is_load | link;
        ctrl.mem_we       = is_store;
        ctrl.res_from_mem = is_load;
        ctrl.mem_type     = (i_ld_h | i_st_h) ? `LA_MEM_H :
                            (i_ld_b | i_st_b) ? `LA_MEM_B :
                            i_ld_hu           ? (`LA_MEM_H | `LA_MEM_UNS) :
                            i_ld_bu           ? (`LA_MEM_B | `LA_MEM_UNS) : `LA_MEM_W;
        ctrl.br_kind      = {i_bne | i_bge | i_bgeu, i_bltu | i_bgeu, i_blt | i_bge, i_beq | i_bne};
        ctrl.is_jump      = i_jirl | i_b | i_bl;
    end

    assign imm = link      ? `LA_GRLEN'd4 :
                 u20       ? {i20, 12'b0} :
                 shift_imm ? {{(`LA_GRLEN-5){1'b0}}, inst.r3.rk} :
                 si12      ? {{(`LA_GRLEN-12){inst.ri.i12[11]}}, inst.ri.i12} :
                 ui12      ? {{(`LA_GRLEN-12){1'b0}}, inst.ri.i12} : '0;

    assign br_offs = (i_b | i_bl) ? {{4{i26[25]}}, i26, 2'b0}
                                  : {{14{i16[15]}}, i16, 2'b0};
endmodule

// File: hw/id_regfile.sv
`timescale 1ns/10ps
`include "la_id_params.svh"

module id_regfile (
    input  logic                     clk,
    input  logic [`LA_RADDR_W-1:0]   raddr1,
    input  logic [`LA_RADDR_W-1:0]   raddr2,
    output logic [`LA_GRLEN-1:0]     rdata1,
    output logic [`LA_GRLEN-1:0]     rdata2,
    input  la_id_pkg::wb_write_t     wr
);
    logic [`LA_GRLEN-1:0] rf [`LA_NREGS];

    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin
            rf[wr.waddr] <= wr.wdata;
        end
    end

    // r0 is hardwired zero
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];
endmodule

// File: hw/id_operand_fwd.sv
`timescale 1ns/10ps
`include "la_id_params.svh"

module id_operand_fwd (
    input  la_id_pkg::dec_ctrl_t    ctrl,
    input  logic [`LA_GRLEN-1:0]    rdata1,
    input  logic [`LA_GRLEN-1:0]    rdata2,
    input  la_id_pkg::fwd_src_t     ex_fwd,
    input  la_id_pkg::fwd_src_t     mem_fwd,
    input  la_id_pkg::wb_write_t    wb_write,
    output logic [`LA_GRLEN-1:0]    rj_value,
    output logic [`LA_GRLEN-1:0]    rkd_value,
    output logic                    load_use_stall
);
    logic live1;
    logic live2;

    // ex beats mem beats wb beats the register file
    function automatic logic [`LA_GRLEN-1:0] pick(
        input logic                    live,
        input logic [`LA_RADDR_W-1:0]  addr,
        input logic [`LA_GRLEN-1:0]    rf_val
    );
        logic [`LA_GRLEN-1:0] val;
        val = rf_val;
        if (live) begin
            if (ex_fwd.valid && ex_fwd.dest == addr)
                val = ex_fwd.wdata;
            else if (mem_fwd.valid && mem_fwd.dest == addr)
                val = mem_fwd.wdata;
            else if (wb_write.we && wb_write.waddr == addr)
                val = wb_write.wdata;
        end
        return val;
    endfunction

    assign live1 = ctrl.need_rj && (ctrl.raddr1 != '0);
    assign live2 = ctrl.need_rkd && (ctrl.raddr2 != '0);

    always_comb begin
        rj_value  = pick(live1, ctrl.raddr1, rdata1);
        rkd_value = pick(live2, ctrl.raddr2, rdata2);
    end

    // load data is not ready until mem
    assign load_use_stall = ex_fwd.valid && ex_fwd.is_load
                         && ((live1 && ex_fwd.dest == ctrl.raddr1)
                          || (live2 && ex_fwd.dest == ctrl.raddr2));
endmodule

// File: hw/id_branch_unit.sv
`timescale 1ns/10ps
`include "la_id_params.svh"

module id_branch_unit (
    input  la_id_pkg::dec_ctrl_t    ctrl,
    input  logic [`LA_GRLEN-1:0]    pc,
    input  logic [`LA_GRLEN-1:0]    br_offs,
    input  logic [`LA_GRLEN-1:0]    rj_value,
    input  logic [`LA_GRLEN-1:0]    rkd_value,
    output logic                    taken,
    output logic [`LA_GRLEN-1:0]    target
);
    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;
    logic is_cbr;

    assign eq   = rj_value == rkd_value;
    assign lt_s = $signed(rj_value) < $signed(rkd_value);
    assign lt_u = rj_value < rkd_value;

    // bne, bge and bgeu are the inverted forms
    assign is_cbr = |ctrl.br_kind[2:0];
    assign cond   = |(ctrl.br_kind[2:0] & {lt_u, lt_s, eq});
    assign taken  = ctrl.is_jump || (is_cbr && (cond ^ ctrl.br_kind[3]));

    // jirl is the only jump that reads rj
    assign target = ((ctrl.is_jump && ctrl.need_rj) ? rj_value : pc) + br_offs;
endmodule

// File: hw/id_stage.sv
`timescale 1ns/10ps
`include "la_id_params.svh"

module id_stage (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     if_valid,
    input  la_id_pkg::if_id_t        if_data,
    output logic                     id_allowin,
    output la_id_pkg::br_redirect_t  br,
    output logic                     id_ex_valid,
    input  logic                     ex_allowin,
    output la_id_pkg::id_ex_t        id_ex,
    input  la_id_pkg::fwd_src_t      ex_fwd,
    input  la_id_pkg::fwd_src_t      mem_fwd,
    input  la_id_pkg::wb_write_t     wb_write
);
    import la_id_pkg::*;

    logic                  id_valid;
    if_id_t                id_data;
    dec_ctrl_t             ctrl;
    logic [`LA_GRLEN-1:0]  imm;
    logic [`LA_GRLEN-1:0]  br_offs;
    logic [`LA_GRLEN-1:0]  rdata1;
    logic [`LA_GRLEN-1:0]  rdata2;
    logic [`LA_GRLEN-1:0]  rj_value;
    logic [`LA_GRLEN-1:0]  rkd_value;
    logic [`LA_GRLEN-1:0]  br_target;
    logic                  load_use_stall;
    logic                  br_taken;
    logic                  id_to_ex;

    assign id_ex_valid = id_valid & ~load_use_stall;
    assign id_to_ex    = id_ex_valid & ex_allowin;
    assign id_allowin  = ~id_valid | id_to_ex;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (id_to_ex && br_taken) begin
            id_valid <= 1'b0;   // drop the wrong-path word
        end else if (id_allowin) begin
            id_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allowin) begin
            id_data <= if_data;
        end
    end

    id_decoder u_dec (
        .inst    (id_data.inst),
        .ctrl    (ctrl),
        .imm     (imm),
        .br_offs (br_offs)
    );

    id_regfile u_rf (
        .clk    (clk),
        .raddr1 (ctrl.raddr1),
        .raddr2 (ctrl.raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wr     (wb_write)
    );

    id_operand_fwd u_fwd (
        .ctrl           (ctrl),
        .rdata1         (rdata1),
        .rdata2         (rdata2),
        .ex_fwd         (ex_fwd),
        .mem_fwd        (mem_fwd),
        .wb_write       (wb_write),
        .rj_value       (rj_value),
        .rkd_value      (rkd_value),
        .load_use_stall (load_use_stall)
    );

    id_branch_unit u_br (
        .ctrl      (ctrl),
        .pc        (id_data.pc),
        .br_offs   (br_offs),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .taken     (br_taken),
        .target    (br_target)
    );

    // redirect only once the branch actually moves on
    assign br.taken  = br_taken & id_to_ex;
    assign br.target = br_target;

    always_comb begin
        id_ex.alu_op       = ctrl.alu_op;
        id_ex.src1         = ctrl.src1_is_pc ? id_data.pc : rj_value;
        id_ex.src2         = ctrl.src2_is_imm ? imm : rkd_value;
        id_ex.rkd_value    = rkd_value;
        id_ex.dest         = ctrl.dest;
        id_ex.gr_we        = ctrl.gr_we;
        id_ex.mem_we       = ctrl.mem_we;
        id_ex.res_from_mem = ctrl.res_from_mem;
        id_ex.mem_type     = ctrl.mem_type;
        id_ex.pc           = id_data.pc;
    end
endmodule

// File: verification/id_stage_properties.sv
`timescale 1ns/10ps

module id_stage_properties (
    input logic                     clk,
    input logic                     resetn,
    input logic                     id_ex_valid,
    input logic                     ex_allowin,
    input la_id_pkg::id_ex_t        id_ex,
    input la_id_pkg::br_redirect_t  br
);
    // decode must come out of reset empty
    empty_after_reset: assert property (@(posedge clk) !resetn |=> !id_ex_valid)
        else $error("id_ex_valid high in the cycle after reset");

    hold_under_backpressure: assert property (@(posedge clk) disable iff (!resetn)
        (id_ex_valid && !ex_allowin) |=> $stable(id_ex))
        else $error("id_ex changed while execute was not accepting");

    redirect_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
        br.taken |-> id_ex_valid)
        else $error("br.taken raised without a valid instruction in decode");
endmodule

// File: verification/id_stage_tb.sv
`timescale 1ns/10ps
`include "la_id_params.svh"

module id_stage_tb;
    import la_id_pkg::*;

    localparam int MAX_CYCLES = 600;
    localparam int ALU_ADD = 0;
    localparam int ALU_AND = 4;
    localparam int ALU_LUI = 11;

    logic          clk;
    logic          resetn;
    logic          if_valid;
    if_id_t        if_data;
    logic          id_allowin;
    br_redirect_t  br;
    logic          id_ex_valid;
    logic          ex_allowin;
    id_ex_t        id_ex;
    fwd_src_t      ex_fwd;
    fwd_src_t      mem_fwd;
    wb_write_t     wb_write;

    logic [31:0] ref_rf [32];   // what the register file should hold
    integer      seed = 32'h91d9;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    id_stage DUT (
        .clk         (clk),
        .resetn      (resetn),
        .if_valid    (if_valid),
        .if_data     (if_data),
        .id_allowin  (id_allowin),
        .br          (br),
        .id_ex_valid (id_ex_valid),
        .ex_allowin  (ex_allowin),
        .id_ex       (id_ex),
        .ex_fwd      (ex_fwd),
        .mem_fwd     (mem_fwd),
        .wb_write    (wb_write)
    );

    bind id_stage id_stage_properties u_props (
        .clk         (clk),
        .resetn      (resetn),
        .id_ex_valid (id_ex_valid),
        .ex_allowin  (ex_allowin),
        .id_ex       (id_ex),
        .br          (br)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: the DUT did not respond within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // instruction encoders
    function automatic logic [31:0] r3_word(input logic [16:0] op, input logic [4:0] rk, rj, rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] ri_word(input logic [9:0] op, input logic [11:0] i12,
                                            input logic [4:0] rj, rd);
        return {op, i12, rj, rd};
    endfunction

    function automatic logic [31:0] u20_word(input logic [6:0] op, input logic [19:0] i20,
                                             input logic [4:0] rd);
        return {op, i20, rd};
    endfunction

    function automatic logic [31:0] br_word(input logic [5:0] op, input logic [15:0] offs,
                                            input logic [4:0] rj, rd);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] jump_word(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};   // high offset bits sit in the low field
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic branch_taken(input logic [5:0] op, input logic [31:0] a, b);
        case (op)
            `LA_OP_BEQ:  return a == b;
            `LA_OP_BNE:  return a != b;
            `LA_OP_BLT:  return $signed(a) < $signed(b);
            `LA_OP_BGE:  return $signed(a) >= $signed(b);
            `LA_OP_BLTU: return a < b;
            default:     return a >= b;   // bgeu
        endcase
    endfunction

    task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic expect_ctrl(input string what, input int alu_bit, input logic [4:0] dest,
                               input logic gr_we, input logic from_mem, input logic [2:0] mtype);
        expect_eq({what, " alu_op"}, id_ex.alu_op, 32'd1 << alu_bit);
        expect_eq({what, " dest"}, id_ex.dest, dest);
        expect_eq({what, " gr_we"}, id_ex.gr_we, gr_we);
        expect_eq({what, " mem_we"}, id_ex.mem_we, 0);
        expect_eq({what, " res_from_mem"}, id_ex.res_from_mem, from_mem);
        expect_eq({what, " mem_type"}, id_ex.mem_type, mtype);
    endtask

    task automatic id_ex_unchanged(input id_ex_t snap);
        checks++;
        assert (id_ex === snap) else begin
            errors++;
            $display("Fail at %0t: id_ex changed while ex_allowin was low", $time);
        end
    endtask

    task automatic rf_write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        wb_write <= '{1'b1, addr, data};
        @(posedge clk);
        wb_write <= '0;
        ref_rf[addr] = data;
    endtask

    // offer one word and return at the edge that accepts it
    task automatic send_inst(input logic [31:0] pc, input logic [31:0] word);
        @(posedge clk);
        if_valid <= 1'b1;
        if_data <= {pc, word};
        @(negedge clk);
        while (!id_allowin) @(negedge clk);
        @(posedge clk);
        if_valid <= 1'b0;
    endtask

    task automatic wait_for_ex();
        @(negedge clk);
        while (!id_ex_valid) @(negedge clk);
    endtask

    task automatic reset_values();
        @(negedge clk);
        expect_eq("reset id_ex_valid", id_ex_valid, 0);
        expect_eq("reset br.taken", br.taken, 0);
        expect_eq("reset id_allowin", id_allowin, 1);
    endtask

    task automatic decode_after_writeback();
        logic [11:0] i12;
        logic [19:0] i20;
        for (int r = 1; r < 32; r++)
            rf_write(r, $random(seed));
        send_inst(32'h1c00_0000, r3_word(`LA_OP_ADD_W, 5'd4, 5'd3, 5'd5));
        wait_for_ex();
        expect_eq("add.w src1", id_ex.src1, ref_rf[3]);
        expect_eq("add.w src2", id_ex.src2, ref_rf[4]);
        expect_eq("add.w rkd_value", id_ex.rkd_value, ref_rf[4]);
        expect_eq("add.w pc", id_ex.pc, 32'h1c00_0000);
        expect_ctrl("add.w", ALU_ADD, 5'd5, 1'b1, 1'b0, `LA_MEM_W);
        i12 = $random(seed);
        send_inst(32'h1c00_0004, ri_word(`LA_OP_ADDI_W, i12, 5'd7, 5'd6));
        wait_for_ex();
        expect_eq("addi.w src1", id_ex.src1, ref_rf[7]);
        expect_eq("addi.w src2", id_ex.src2, sext12(i12));
        expect_ctrl("addi.w", ALU_ADD, 5'd6, 1'b1, 1'b0, `LA_MEM_W);
        i12 = $random(seed);
        send_inst(32'h1c00_0008, ri_word(`LA_OP_ANDI, i12, 5'd8, 5'd9));
        wait_for_ex();
        expect_eq("andi src2", id_ex.src2, {20'b0, i12});   // logical immediates zero-extend
        expect_ctrl("andi", ALU_AND, 5'd9, 1'b1, 1'b0, `LA_MEM_W);
        i20 = $random(seed);
        send_inst(32'h1c00_000c, u20_word(`LA_OP_LU12I_W, i20, 5'd10));
        wait_for_ex();
        expect_eq("lu12i.w src2", id_ex.src2, {i20, 12'b0});
        expect_ctrl("lu12i.w", ALU_LUI, 5'd10, 1'b1, 1'b0, `LA_MEM_W);
        i12 = $random(seed);
        send_inst(32'h1c00_0010, ri_word(`LA_OP_LD_HU, i12, 5'd11, 5'd12));
        wait_for_ex();
        expect_eq("ld.hu src1", id_ex.src1, ref_rf[11]);
        expect_eq("ld.hu src2", id_ex.src2, sext12(i12));
        expect_ctrl("ld.hu", ALU_ADD, 5'd12, 1'b1, 1'b1, `LA_MEM_H | `LA_MEM_UNS);
    endtask

    task automatic forwarding_priority();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        @(posedge clk);
        ex_fwd <= '{1'b1, 1'b0, 5'd9, a};
        mem_fwd <= '{1'b1, 1'b0, 5'd9, b};
        wb_write <= '{1'b1, 5'd9, c};
        ref_rf[9] = c;   // wb also lands in the register file
        send_inst(32'h1c00_0100, r3_word(`LA_OP_ADD_W, 5'd10, 5'd9, 5'd8));
        wait_for_ex();
        expect_eq("ex over mem and wb", id_ex.src1, a);
        expect_eq("unforwarded src2", id_ex.src2, ref_rf[10]);
        @(posedge clk);
        ex_fwd <= '0;
        send_inst(32'h1c00_0104, r3_word(`LA_OP_ADD_W, 5'd10, 5'd9, 5'd8));
        wait_for_ex();
        expect_eq("mem over wb", id_ex.src1, b);
        @(posedge clk);
        mem_fwd <= '0;
        wb_write <= '0;
        ex_fwd <= '{1'b1, 1'b0, 5'd0, a};
        send_inst(32'h1c00_0108, r3_word(`LA_OP_ADD_W, 5'd0, 5'd0, 5'd11));
        wait_for_ex();
        expect_eq("r0 src1", id_ex.src1, 0);
        expect_eq("r0 src2", id_ex.src2, 0);
        @(posedge clk);
        ex_fwd <= '0;
    endtask

    task automatic load_use_stall();
        logic [31:0] d;
        d = $random(seed);
        @(posedge clk);
        ex_fwd <= '{1'b1, 1'b1, 5'd12, 32'h0};
        send_inst(32'h1c00_0200, r3_word(`LA_OP_ADD_W, 5'd14, 5'd12, 5'd13));
        repeat (3) begin
            @(negedge clk);
            expect_eq("stalled id_ex_valid", id_ex_valid, 0);
            expect_eq("stalled id_allowin", id_allowin, 0);
        end
        @(posedge clk);
        ex_fwd <= '0;
        mem_fwd <= '{1'b1, 1'b1, 5'd12, d};   // load now in mem with its data
        wait_for_ex();
        expect_eq("load-use src1", id_ex.src1, d);
        expect_eq("load-use src2", id_ex.src2, ref_rf[14]);
        @(posedge clk);
        mem_fwd <= '0;
    endtask

    task automatic branch_checks();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] pc;
        logic [15:0] offs;
        logic [25:0] offs26;
        logic [5:0]  ops [6];
        ops = '{`LA_OP_BEQ, `LA_OP_BNE, `LA_OP_BLT, `LA_OP_BGE, `LA_OP_BLTU, `LA_OP_BGEU};
        a = $random(seed) | 32'h8000_0000;   // negative so signed and unsigned compares disagree
        b = $random(seed) & 32'h7fff_ffff;
        for (int p = 0; p < 3; p++) begin
            x = (p == 1) ? b : a;
            y = (p == 0) ? b : a;
            rf_write(5'd15, x);
            rf_write(5'd16, y);
            for (int k = 0; k < 6; k++) begin
                pc = 32'h1c00_1000 + (k << 4);
                offs = $random(seed);
                send_inst(pc, br_word(ops[k], offs, 5'd15, 5'd16));
                wait_for_ex();
                expect_eq($sformatf("op %h taken", ops[k]), br.taken, branch_taken(ops[k], x, y));
                expect_eq($sformatf("op %h target", ops[k]), br.target,
                          pc + {{14{offs[15]}}, offs, 2'b00});
            end
        end
        pc = 32'h1c00_2000;
        offs = $random(seed);
        send_inst(pc, br_word(`LA_OP_JIRL, offs, 5'd15, 5'd18));
        wait_for_ex();
        expect_eq("jirl taken", br.taken, 1);
        expect_eq("jirl target", br.target, ref_rf[15] + {{14{offs[15]}}, offs, 2'b00});
        expect_eq("jirl dest", id_ex.dest, 18);
        expect_eq("jirl link src1", id_ex.src1, pc);
        pc = 32'h1c00_2040;
        offs26 = $random(seed);
        send_inst(pc, jump_word(`LA_OP_BL, offs26));
        wait_for_ex();
        expect_eq("bl taken", br.taken, 1);
        expect_eq("bl target", br.target, pc + {{4{offs26[25]}}, offs26, 2'b00});
        expect_eq("bl dest", id_ex.dest, 1);
        expect_eq("bl src2", id_ex.src2, 4);
        pc = 32'h1c00_2100;
        send_inst(pc, jump_word(`LA_OP_B, offs26));
        // fetch offers a wrong-path word in the redirect cycle
        if_valid <= 1'b1;
        if_data <= {32'hbad0_0000, ri_word(`LA_OP_ADDI_W, 12'h001, 5'd1, 5'd2)};
        @(negedge clk);
        expect_eq("b taken", br.taken, 1);
        @(posedge clk);
        if_valid <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            expect_eq("wrong-path id_ex_valid", id_ex_valid, 0);
        end
    endtask

    task automatic back_pressure();
        id_ex_t snap;
        @(posedge clk);
        ex_allowin <= 1'b0;
        send_inst(32'h1c00_3000, r3_word(`LA_OP_XOR, 5'd20, 5'd19, 5'd21));
        if_valid <= 1'b1;   // next word waits on fetch through the stall
        if_data <= {32'h1c00_3004, r3_word(`LA_OP_OR, 5'd23, 5'd22, 5'd24)};
        wait_for_ex();
        snap = id_ex;
        expect_eq("held src1", snap.src1, ref_rf[19]);
        expect_eq("held src2", snap.src2, ref_rf[20]);
        repeat (3) begin
            @(negedge clk);
            id_ex_unchanged(snap);
            expect_eq("held id_allowin", id_allowin, 0);
            expect_eq("held id_ex_valid", id_ex_valid, 1);
        end
        @(posedge clk);
        ex_allowin <= 1'b1;
        @(negedge clk);
        expect_eq("release id_ex_valid", id_ex_valid, 1);
        expect_eq("release id_allowin", id_allowin, 1);
        @(posedge clk);
        if_valid <= 1'b0;
        @(negedge clk);
        expect_eq("next id_ex_valid", id_ex_valid, 1);
        expect_eq("next pc", id_ex.pc, 32'h1c00_3004);
        expect_eq("next src1", id_ex.src1, ref_rf[22]);
    endtask

    initial begin
        resetn = 1'b0;
        if_valid = 1'b0;
        if_data = '0;
        ex_allowin = 1'b1;
        ex_fwd = '0;
        mem_fwd = '0;
        wb_write = '0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        reset_values();
        decode_after_writeback();
        forwarding_priority();
        load_use_stall();
        branch_checks();
        back_pressure();
        repeat (2) @(posedge clk);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end
endmodule

// File: loongarch_id.f
+incdir+hw
hw/la_id_pkg.sv
hw/id_decoder.sv
hw/id_regfile.sv
hw/id_operand_fwd.sv
hw/id_branch_unit.sv
hw/id_stage.sv
verification/id_stage_properties.sv
verification/id_stage_tb.sv
